/* hw/serv_pkg.sv */
`default_nettype none

package serv_pkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;
   localparam int CNT_W      = 5;

   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

   // Major opcodes of the supported subset
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_SW  = 3'b010;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_SUB  = 7'b0100000;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_OR,
      ALU_AND,
      ALU_PASS_B
   } alu_op_e;

   typedef struct packed {
      alu_op_e alu_op;
      logic    op_b_imm;
      logic    rd_wen;
      logic    is_store;
      logic    is_lui;
   } ctrl_t;

   typedef struct packed {
      logic [XLEN-1:0] adr;
      logic [XLEN-1:0] dat;
   } dbus_req_t;

endpackage

`default_nettype wire

/* hw/serv_state.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_state (
   input  wire                        clk,
   input  wire                        i_rst_n,
   input  wire                        i_ibus_ack,
   input  wire                        i_dbus_ack,
   input  wire                        i_is_store,
   output logic                       o_ibus_cyc,
   output logic                       o_dbus_cyc,
   output logic                       o_cnt_en,
   output logic                       o_cnt_done,
   output logic [serv_pkg::CNT_W-1:0] o_cnt
);

   typedef enum logic [1:0] {
      ST_FETCH,
      ST_EXEC,
      ST_STORE
   } state_e;

   state_e state_q;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= ST_FETCH;
         o_cnt   <= '0;
      end else begin
         case (state_q)
            ST_FETCH: begin
               if (i_ibus_ack) begin
                  state_q <= ST_EXEC;
               end
            end
            ST_EXEC: begin
               // Counter wraps back to zero on the last bit
               o_cnt <= o_cnt + 1'b1;
               if (o_cnt_done) begin
                  state_q <= i_is_store ? ST_STORE : ST_FETCH;
               end
            end
            ST_STORE: begin
               if (i_dbus_ack) begin
                  state_q <= ST_FETCH;
               end
            end
            default: begin
               state_q <= ST_FETCH;
            end
         endcase
      end
   end

   assign o_ibus_cyc = (state_q == ST_FETCH);
   assign o_dbus_cyc = (state_q == ST_STORE);
   assign o_cnt_en   = (state_q == ST_EXEC);
   assign o_cnt_done = o_cnt_en && (&o_cnt);

endmodule

`default_nettype wire

/* hw/serv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_decode (
   input  wire                             clk,
   input  wire                             i_rst_n,
   input  wire                             i_ibus_ack,
   input  wire [serv_pkg::XLEN-1:0]        i_instr,
   output serv_pkg::ctrl_t                 o_ctrl,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_rs1_addr,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_rs2_addr,
   output logic [serv_pkg::REG_ADDR_W-1:0] o_rd_addr
);

   logic [6:0]                      opcode_q;
   logic [2:0]                      funct3_q;
   logic [6:0]                      funct7_q;
   logic [serv_pkg::REG_ADDR_W-1:0] rs1_q;

   // Cleared opcode decodes as a no-op
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         opcode_q <= '0;
      end else if (i_ibus_ack) begin
         opcode_q <= i_instr[6:0];
      end
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         funct3_q   <= i_instr[14:12];
         funct7_q   <= i_instr[31:25];
         o_rd_addr  <= i_instr[11:7];
         rs1_q      <= i_instr[19:15];
         o_rs2_addr <= i_instr[24:20];
      end
   end

   always_comb begin
      o_ctrl        = '0;
      o_ctrl.alu_op = serv_pkg::ALU_ADD;
      case (opcode_q)
         serv_pkg::OPC_OP_IMM: begin
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.rd_wen   = 1'b1;
            case (funct3_q)
               serv_pkg::F3_ADD: o_ctrl.alu_op = serv_pkg::ALU_ADD;
               serv_pkg::F3_XOR: o_ctrl.alu_op = serv_pkg::ALU_XOR;
               serv_pkg::F3_OR:  o_ctrl.alu_op = serv_pkg::ALU_OR;
               serv_pkg::F3_AND: o_ctrl.alu_op = serv_pkg::ALU_AND;
               default:          o_ctrl.rd_wen = 1'b0;
            endcase
         end
         serv_pkg::OPC_OP: begin
            o_ctrl.rd_wen = 1'b1;
            if (funct7_q == serv_pkg::F7_SUB && funct3_q == serv_pkg::F3_ADD) begin
               o_ctrl.alu_op = serv_pkg::ALU_SUB;
            end else if (funct7_q == serv_pkg::F7_BASE) begin
               case (funct3_q)
                  serv_pkg::F3_ADD: o_ctrl.alu_op = serv_pkg::ALU_ADD;
                  serv_pkg::F3_XOR: o_ctrl.alu_op = serv_pkg::ALU_XOR;
                  serv_pkg::F3_OR:  o_ctrl.alu_op = serv_pkg::ALU_OR;
                  serv_pkg::F3_AND: o_ctrl.alu_op = serv_pkg::ALU_AND;
                  default:          o_ctrl.rd_wen = 1'b0;
               endcase
            end else begin
               o_ctrl.rd_wen = 1'b0;
            end
         end
         serv_pkg::OPC_LUI: begin
            o_ctrl.alu_op   = serv_pkg::ALU_PASS_B;
            o_ctrl.op_b_imm = 1'b1;
            o_ctrl.rd_wen   = 1'b1;
            o_ctrl.is_lui   = 1'b1;
         end
         // Word stores only, rd never written
         serv_pkg::OPC_STORE: begin
            o_ctrl.is_store = (funct3_q == serv_pkg::F3_SW);
         end
         default: begin
         end
      endcase
   end

   assign o_rs1_addr = o_ctrl.is_lui ? '0 : rs1_q;

endmodule

`default_nettype wire

/* hw/serv_immdec.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_immdec (
   input  wire                      clk,
   input  wire                      i_ibus_ack,
   input  wire                      i_cnt_en,
   input  wire [serv_pkg::XLEN-1:0] i_instr,
   output logic                     o_imm_bit
);

   logic [serv_pkg::XLEN-1:0] imm_q;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         case (i_instr[6:0])
            serv_pkg::OPC_STORE: begin
               imm_q <= {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            end
            serv_pkg::OPC_LUI: begin
               imm_q <= {i_instr[31:12], 12'h000};
            end
            // I-type also covers the no-op encodings
            default: begin
               imm_q <= {{20{i_instr[31]}}, i_instr[31:20]};
            end
         endcase
      end else if (i_cnt_en) begin
         imm_q <= {imm_q[0], imm_q[serv_pkg::XLEN-1:1]};
      end
   end

   // LSB first
   assign o_imm_bit = imm_q[0];

endmodule

`default_nettype wire

/* hw/serv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_alu (
   input  wire             clk,
   input  wire             i_cnt_en,
   input  wire             i_cnt_done,
   input  wire             i_rs1_bit,
   input  wire             i_imm_bit,
   input  wire             i_rs2_bit,
   input  serv_pkg::ctrl_t i_ctrl,
   output logic            o_rd_bit
);

   logic op_b;
   logic is_sub;
   logic b_eff;
   logic carry_q;
   logic carry_in;
   logic carry_out;
   logic sum;

   assign op_b   = i_ctrl.op_b_imm ? i_imm_bit : i_rs2_bit;
   assign is_sub = (i_ctrl.alu_op == serv_pkg::ALU_SUB);
   assign b_eff  = op_b ^ is_sub;

   // Flop holds carry xor sub, so a cleared flop means carry-in of one for sub
   assign carry_in  = carry_q ^ is_sub;
   assign sum       = i_rs1_bit ^ b_eff ^ carry_in;
   assign carry_out = (i_rs1_bit & b_eff) | (carry_in & (i_rs1_bit ^ b_eff));

   always_ff @(posedge clk) begin
      if (i_cnt_en && !i_cnt_done) begin
         carry_q <= carry_out ^ is_sub;
      end else begin
         carry_q <= 1'b0;
      end
   end

   always_comb begin
      case (i_ctrl.alu_op)
         serv_pkg::ALU_ADD,
         serv_pkg::ALU_SUB:    o_rd_bit = sum;
         serv_pkg::ALU_XOR:    o_rd_bit = i_rs1_bit ^ op_b;
         serv_pkg::ALU_OR:     o_rd_bit = i_rs1_bit | op_b;
         serv_pkg::ALU_AND:    o_rd_bit = i_rs1_bit & op_b;
         serv_pkg::ALU_PASS_B: o_rd_bit = op_b;
         default:              o_rd_bit = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/serv_bufreg.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_bufreg (
   input  wire                 clk,
   input  wire                 i_cnt_en,
   input  wire                 i_cnt_done,
   input  wire                 i_rs1_bit,
   input  wire                 i_imm_bit,
   input  wire                 i_rs2_bit,
   output serv_pkg::dbus_req_t o_dbus
);

   logic carry_q;
   logic adr_bit;
   logic carry_out;

   // Effective address rs1 + imm, one bit per cycle
   assign adr_bit   = i_rs1_bit ^ i_imm_bit ^ carry_q;
   assign carry_out = (i_rs1_bit & i_imm_bit) | (carry_q & (i_rs1_bit ^ i_imm_bit));

   always_ff @(posedge clk) begin
      if (i_cnt_en && !i_cnt_done) begin
         carry_q <= carry_out;
      end else begin
         carry_q <= 1'b0;
      end
   end

   // Held after execute for the store phase
   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         o_dbus.adr <= {adr_bit, o_dbus.adr[serv_pkg::XLEN-1:1]};
         o_dbus.dat <= {i_rs2_bit, o_dbus.dat[serv_pkg::XLEN-1:1]};
      end
   end

endmodule

`default_nettype wire

/* hw/serv_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_ctrl (
   input  wire                        clk,
   input  wire                        i_rst_n,
   input  wire                        i_cnt_en,
   input  wire                        i_cnt_done,
   input  wire [serv_pkg::CNT_W-1:0]  i_cnt,
   output logic [serv_pkg::XLEN-1:0]  o_ibus_adr
);

   logic inc_bit;
   logic carry_q;
   logic pc_bit;
   logic carry_out;

   // Plus four, i.e. a one at bit 2
   assign inc_bit   = (i_cnt == serv_pkg::CNT_W'(2));
   assign pc_bit    = o_ibus_adr[0] ^ inc_bit ^ carry_q;
   assign carry_out = (o_ibus_adr[0] & inc_bit) | (carry_q & (o_ibus_adr[0] ^ inc_bit));

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_ibus_adr <= serv_pkg::RESET_PC;
         carry_q    <= 1'b0;
      end else if (i_cnt_en) begin
         o_ibus_adr <= {pc_bit, o_ibus_adr[serv_pkg::XLEN-1:1]};
         carry_q    <= i_cnt_done ? 1'b0 : carry_out;
      end
   end

endmodule

`default_nettype wire

/* hw/serv_rf.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_rf (
   input  wire                             clk,
   input  wire                             i_cnt_en,
   input  wire                             i_wen,
   input  wire                             i_rd_bit,
   input  wire [serv_pkg::CNT_W-1:0]       i_cnt,
   input  wire [serv_pkg::REG_ADDR_W-1:0]  i_rs1_addr,
   input  wire [serv_pkg::REG_ADDR_W-1:0]  i_rs2_addr,
   input  wire [serv_pkg::REG_ADDR_W-1:0]  i_rd_addr,
   output logic                            o_rs1_bit,
   output logic                            o_rs2_bit
);

   localparam int NUM_REGS = 2 ** serv_pkg::REG_ADDR_W;

   logic [serv_pkg::XLEN-1:0] regs [NUM_REGS];
   logic                      rd_is_x0;

   assign rd_is_x0 = (i_rd_addr == '0);

   // Bit cnt is written at the end of the cycle that reads it
   always_ff @(posedge clk) begin
      if (i_cnt_en && i_wen && !rd_is_x0) begin
         regs[i_rd_addr][i_cnt] <= i_rd_bit;
      end
   end

   // x0 never written, masked on read
   assign o_rs1_bit = (i_rs1_addr == '0) ? 1'b0 : regs[i_rs1_addr][i_cnt];
   assign o_rs2_bit = (i_rs2_addr == '0) ? 1'b0 : regs[i_rs2_addr][i_cnt];

endmodule

`default_nettype wire

/* hw/serv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_top (
   input  wire                      clk,
   input  wire                      i_rst_n,
   input  wire                      i_ibus_ack,
   input  wire                      i_dbus_ack,
   input  wire [serv_pkg::XLEN-1:0] i_ibus_rdt,
   output wire                      o_ibus_cyc,
   output wire                      o_dbus_cyc,
   output wire [serv_pkg::XLEN-1:0] o_ibus_adr,
   output serv_pkg::dbus_req_t      o_dbus
);

   serv_pkg::ctrl_t                 ctrl;
   logic [serv_pkg::REG_ADDR_W-1:0] rs1_addr;
   logic [serv_pkg::REG_ADDR_W-1:0] rs2_addr;
   logic [serv_pkg::REG_ADDR_W-1:0] rd_addr;
   logic [serv_pkg::CNT_W-1:0]      cnt;
   logic                            cnt_en;
   logic                            cnt_done;
   logic                            imm_bit;
   logic                            rs1_bit;
   logic                            rs2_bit;
   logic                            rd_bit;

   serv_state state (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_is_store (ctrl.is_store),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc),
      .o_cnt_en   (cnt_en),
      .o_cnt_done (cnt_done),
      .o_cnt      (cnt)
   );

   serv_decode decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_instr    (i_ibus_rdt),
      .o_ctrl     (ctrl),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_rd_addr  (rd_addr)
   );

   serv_immdec immdec (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_cnt_en   (cnt_en),
      .i_instr    (i_ibus_rdt),
      .o_imm_bit  (imm_bit)
   );

   serv_alu alu (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_cnt_done (cnt_done),
      .i_rs1_bit  (rs1_bit),
      .i_imm_bit  (imm_bit),
      .i_rs2_bit  (rs2_bit),
      .i_ctrl     (ctrl),
      .o_rd_bit   (rd_bit)
   );

   serv_bufreg bufreg (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_cnt_done (cnt_done),
      .i_rs1_bit  (rs1_bit),
      .i_imm_bit  (imm_bit),
      .i_rs2_bit  (rs2_bit),
      .o_dbus     (o_dbus)
   );

   serv_ctrl ctrl_pc (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_cnt_en   (cnt_en),
      .i_cnt_done (cnt_done),
      .i_cnt      (cnt),
      .o_ibus_adr (o_ibus_adr)
   );

   serv_rf rf (
      .clk        (clk),
      .i_cnt_en   (cnt_en),
      .i_wen      (ctrl.rd_wen),
      .i_rd_bit   (rd_bit),
      .i_cnt      (cnt),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit)
   );

endmodule

`default_nettype wire

/* verification/serv_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module serv_tb;

   localparam int SEED_INIT = 11274;
   localparam int INIT_LEN  = 62;
   localparam int BODY_LEN  = 200;
   localparam int DUMP_LEN  = 32;
   localparam int PROG_LEN  = INIT_LEN + BODY_LEN + DUMP_LEN;
   localparam int MAX_DELAY = 3;
   // Worst case per instruction is two delayed bus phases plus 32 execute cycles
   localparam int TIMEOUT_CYCLES = PROG_LEN * (32 + 2 * MAX_DELAY + 4) + 100;

   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   logic                clk;
   logic                i_rst_n = 1'b0;
   logic                i_ibus_ack = 1'b0;
   logic                i_dbus_ack = 1'b0;
   logic [31:0]         i_ibus_rdt = '0;
   wire                 o_ibus_cyc;
   wire                 o_dbus_cyc;
   wire  [31:0]         o_ibus_adr;
   serv_pkg::dbus_req_t o_dbus;

   integer              seed = SEED_INIT;
   logic [31:0]         prog [PROG_LEN];
   logic [31:0]         model_regs [32];
   logic [31:0]         model_pc;
   serv_pkg::dbus_req_t store_q [$];
   serv_pkg::dbus_req_t dbus_hold;
   logic [31:0]         ibus_adr_hold;
   bit                  prog_built = 1'b0;
   bit                  ibus_busy = 1'b0;
   bit                  dbus_busy = 1'b0;
   bit                  ibus_after_ack = 1'b0;
   bit                  dbus_after_ack = 1'b0;
   bit                  done = 1'b0;
   bit                  timed_out = 1'b0;
   int                  ibus_wait = 0;
   int                  dbus_wait = 0;
   int                  fetch_cnt = 0;
   int                  cycle_cnt = 0;
   int                  check_cnt = 0;
   int                  error_cnt = 0;
   int                  test_num = 0;
   int                  test_err_base = 0;

   serv_top serv_top_inst (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc),
      .o_ibus_adr (o_ibus_adr),
      .o_dbus     (o_dbus)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic int unsigned rand_below(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [6:0] opc);
      return {f7, rs2, rs1, f3, rd, opc};
   endfunction

   function automatic logic [31:0] stype_word(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [6:0] opc);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
   endfunction

   function automatic logic [31:0] utype_word(input logic [19:0] upper, input logic [4:0] rd,
                                              input logic [6:0] opc);
      return {upper, rd, opc};
   endfunction

   function automatic logic [31:0] random_instr();
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [11:0] imm;
      logic [19:0] upper;
      logic [31:0] word;
      rd    = 5'(rand_below(32));
      rs1   = 5'(rand_below(32));
      rs2   = 5'(rand_below(32));
      imm   = 12'($random(seed));
      upper = 20'($random(seed));
      // About one in ten falls outside the supported set
      if (rand_below(10) == 0) begin
         case (rand_below(8))
            0:       word = itype_word(imm, rs1, 3'b010, rd, 7'b0000011);
            1:       word = stype_word(imm, rs2, rs1, 3'b000, 7'b1100011);
            2:       word = utype_word(upper, rd, 7'b1101111);
            3:       word = utype_word(upper, rd, 7'b0010111);
            4:       word = itype_word({7'd0, imm[4:0]}, rs1, 3'b001, rd, OPC_OP_IMM);
            5:       word = rtype_word(7'h00, rs2, rs1, 3'b010, rd, OPC_OP);
            6:       word = stype_word(imm, rs2, rs1, 3'b000, OPC_STORE);
            default: word = rtype_word(7'h20, rs2, rs1, 3'b101, rd, OPC_OP);
         endcase
      end else begin
         case (rand_below(11))
            0:       word = itype_word(imm, rs1, 3'b000, rd, OPC_OP_IMM);
            1:       word = itype_word(imm, rs1, 3'b100, rd, OPC_OP_IMM);
            2:       word = itype_word(imm, rs1, 3'b110, rd, OPC_OP_IMM);
            3:       word = itype_word(imm, rs1, 3'b111, rd, OPC_OP_IMM);
            4:       word = rtype_word(7'h00, rs2, rs1, 3'b000, rd, OPC_OP);
            5:       word = rtype_word(7'h20, rs2, rs1, 3'b000, rd, OPC_OP);
            6:       word = rtype_word(7'h00, rs2, rs1, 3'b100, rd, OPC_OP);
            7:       word = rtype_word(7'h00, rs2, rs1, 3'b110, rd, OPC_OP);
            8:       word = rtype_word(7'h00, rs2, rs1, 3'b111, rd, OPC_OP);
            9:       word = utype_word(upper, rd, OPC_LUI);
            default: word = stype_word(imm, rs2, rs1, 3'b010, OPC_STORE);
         endcase
      end
      return word;
   endfunction

   task automatic build_program();
      int k;
      k = 0;
      // Known value in every register before the random part
      for (int n = 1; n < 32; n++) begin
         prog[k]     = utype_word(20'($random(seed)), 5'(n), OPC_LUI);
         prog[k + 1] = itype_word(12'($random(seed)), 5'(n), 3'b000, 5'(n), OPC_OP_IMM);
         k += 2;
      end
      for (int n = 0; n < BODY_LEN; n++) begin
         prog[k] = random_instr();
         k++;
      end
      // Every register out on the data bus including x0
      for (int n = 0; n < DUMP_LEN; n++) begin
         prog[k] = stype_word(12'(256 + 4 * n), 5'(n), 5'd0, 3'b010, OPC_STORE);
         k++;
      end
   endtask

   task automatic model_exec(input logic [31:0] instr);
      logic [6:0]          opc;
      logic [2:0]          f3;
      logic [6:0]          f7;
      logic [4:0]          rd;
      logic [31:0]         a;
      logic [31:0]         b;
      logic [31:0]         imm_i;
      logic [31:0]         imm_s;
      logic [31:0]         res;
      logic                wr;
      serv_pkg::dbus_req_t req;
      opc   = instr[6:0];
      f3    = instr[14:12];
      f7    = instr[31:25];
      rd    = instr[11:7];
      a     = model_regs[instr[19:15]];
      b     = model_regs[instr[24:20]];
      imm_i = {{20{instr[31]}}, instr[31:20]};
      imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      res   = '0;
      wr    = 1'b0;
      case (opc)
         OPC_OP_IMM: begin
            wr = 1'b1;
            case (f3)
               3'b000:  res = a + imm_i;
               3'b100:  res = a ^ imm_i;
               3'b110:  res = a | imm_i;
               3'b111:  res = a & imm_i;
               default: wr = 1'b0;
            endcase
         end
         OPC_OP: begin
            wr = 1'b1;
            if (f7 == 7'h20 && f3 == 3'b000) begin
               res = a - b;
            end else if (f7 == 7'h00) begin
               case (f3)
                  3'b000:  res = a + b;
                  3'b100:  res = a ^ b;
                  3'b110:  res = a | b;
                  3'b111:  res = a & b;
                  default: wr = 1'b0;
               endcase
            end else begin
               wr = 1'b0;
            end
         end
         OPC_LUI: begin
            wr  = 1'b1;
            res = {instr[31:12], 12'h000};
         end
         OPC_STORE: begin
            if (f3 == 3'b010) begin
               req.adr = a + imm_s;
               req.dat = b;
               store_q.push_back(req);
            end
         end
         default: begin
         end
      endcase
      if (wr && rd != 5'd0) begin
         model_regs[rd] = res;
      end
      model_pc = model_pc + 32'd4;
   endtask

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      check_cnt++;
      if (got !== exp) begin
         error_cnt++;
         $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic report_error(input string msg);
      error_cnt++;
      $display("error: %s", msg);
   endtask

   task automatic finish_test(input string name);
      int errs;
      errs = error_cnt - test_err_base;
      test_num++;
      $display("test %0d, %s: %s, %0d errors", test_num, name, (errs == 0) ? "pass" : "fail",
               errs);
      test_err_base = error_cnt;
   endtask

   task automatic start_fetch();
      int idx;
      idx           = int'(model_pc >> 2);
      ibus_busy     = 1'b1;
      ibus_adr_hold = o_ibus_adr;
      fetch_cnt++;
      if (fetch_cnt == 1) begin
         compare("o_ibus_adr after reset", o_ibus_adr, serv_pkg::RESET_PC);
         compare("o_dbus_cyc after reset", 32'(o_dbus_cyc), 32'd0);
         finish_test("reset");
      end
      compare("o_ibus_adr", o_ibus_adr, model_pc);
      if (store_q.size() != 0) begin
         report_error("a SW finished without any request on the data bus");
         store_q.delete();
      end
      if (idx == INIT_LEN + BODY_LEN) begin
         finish_test("random program");
      end
      if (idx >= PROG_LEN) begin
         finish_test("register dump");
         done = 1'b1;
      end
      ibus_wait = int'(rand_below(MAX_DELAY + 1));
   endtask

   task automatic watch_ibus();
      int idx;
      if (i_ibus_ack) begin
         i_ibus_ack    <= 1'b0;
         // Instruction word is valid only in the ack cycle
         i_ibus_rdt    <= ~i_ibus_rdt;
         ibus_after_ack = 1'b1;
      end else if (ibus_after_ack) begin
         compare("o_ibus_cyc after ack", 32'(o_ibus_cyc), 32'd0);
         ibus_after_ack = 1'b0;
      end else if (o_ibus_cyc) begin
         if (!ibus_busy) begin
            start_fetch();
         end else begin
            compare("o_ibus_adr held", o_ibus_adr, ibus_adr_hold);
         end
         if (ibus_busy && !done) begin
            if (ibus_wait == 0) begin
               idx = int'(model_pc >> 2);
               i_ibus_rdt <= prog[idx];
               i_ibus_ack <= 1'b1;
               model_exec(prog[idx]);
               ibus_busy = 1'b0;
            end else begin
               ibus_wait--;
            end
         end
      end else if (ibus_busy) begin
         report_error("o_ibus_cyc dropped before the ack");
         ibus_busy = 1'b0;
      end
   endtask

   task automatic watch_dbus();
      serv_pkg::dbus_req_t exp;
      if (i_dbus_ack) begin
         i_dbus_ack    <= 1'b0;
         dbus_after_ack = 1'b1;
      end else if (dbus_after_ack) begin
         compare("o_dbus_cyc after ack", 32'(o_dbus_cyc), 32'd0);
         dbus_after_ack = 1'b0;
      end else if (o_dbus_cyc) begin
         if (!dbus_busy) begin
            dbus_busy = 1'b1;
            dbus_hold = o_dbus;
            dbus_wait = int'(rand_below(MAX_DELAY + 1));
            if (store_q.size() == 0) begin
               report_error("the data bus made a request with no SW pending");
            end else begin
               exp = store_q.pop_front();
               compare("o_dbus.adr", o_dbus.adr, exp.adr);
               compare("o_dbus.dat", o_dbus.dat, exp.dat);
            end
         end else begin
            compare("o_dbus.adr held", o_dbus.adr, dbus_hold.adr);
            compare("o_dbus.dat held", o_dbus.dat, dbus_hold.dat);
         end
         if (dbus_wait == 0) begin
            i_dbus_ack <= 1'b1;
            dbus_busy = 1'b0;
         end else begin
            dbus_wait--;
         end
      end else if (dbus_busy) begin
         report_error("o_dbus_cyc dropped before the ack");
         dbus_busy = 1'b0;
      end
   endtask

   // Bus responders and reference model sample on the rising edge
   always @(posedge clk) begin
      if (!i_rst_n) begin
         if (!prog_built) begin
            build_program();
            prog_built = 1'b1;
         end
         model_pc = serv_pkg::RESET_PC;
         for (int n = 0; n < 32; n++) begin
            model_regs[n] = '0;
         end
      end else if (!done && !timed_out) begin
         cycle_cnt++;
         if (o_ibus_cyc && o_dbus_cyc) begin
            report_error("instruction and data bus requests are active at the same time");
         end
         watch_dbus();
         watch_ibus();
         if (cycle_cnt >= TIMEOUT_CYCLES && !done) begin
            report_error($sformatf("run timed out after %0d cycles", cycle_cnt));
            timed_out = 1'b1;
         end
      end
   end

   initial begin
      repeat (4) @(posedge clk);
      i_rst_n <= 1'b1;
      while (!done && !timed_out) begin
         @(posedge clk);
      end
      $display("%0d checks, %0d errors", check_cnt, error_cnt);
      if (error_cnt == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
hw/serv_pkg.sv
hw/serv_state.sv
hw/serv_decode.sv
hw/serv_immdec.sv
hw/serv_alu.sv
hw/serv_bufreg.sv
hw/serv_ctrl.sv
hw/serv_rf.sv
hw/serv_top.sv
verification/serv_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= serv_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test OK

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
